// File: source/zx_tape_pkg.sv
// tape loader shared constants

package zx_tape_pkg;

	// ========================================
	// widths
	// ========================================

	// tape buffer address, 16 KB image
	localparam int TAPE_AW = 14;
	// cpu bus
	localparam int ADDR_W = 16;
	localparam int BYTE_W = 8;
	// free running enable counter
	localparam int CE_DIV_W = 5;

	// ========================================
	// rom load routine
	// ========================================

	// entry address of the load routine, per model
	localparam logic [ADDR_W-1:0] TRAP_ZX81 = 16'h0347;
	localparam logic [ADDR_W-1:0] TRAP_ZX80 = 16'h0207;
	// first address past the routine
	localparam logic [ADDR_W-1:0] WIN_END_ZX81 = 16'h03C3;
	localparam logic [ADDR_W-1:0] WIN_END_ZX80 = 16'h024D;

	// ========================================
	// patch routine
	// ========================================

	localparam int PATCH_LEN = 7;
	// loop byte, nop keeps looping, scf exits
	localparam logic [BYTE_W-1:0] OP_NOP = 8'h00;
	localparam logic [BYTE_W-1:0] OP_SCF = 8'h37;
	// xor a / nop / jr nc,-3 / jp 0207h
	localparam logic [BYTE_W-1:0] PATCH_IMAGE [0:PATCH_LEN-1] = '{
		8'hAF, 8'h00, 8'h30, 8'hFD, 8'hC3, 8'h07, 8'h02
	};
	// low byte of the jump target
	localparam logic [BYTE_W-1:0] JMP_LO_ZX81 = 8'h07;
	localparam logic [BYTE_W-1:0] JMP_LO_ZX80 = 8'h03;

	// ram pointer preset, one below the first byte written
	// .p files skip the system variables below 4009h
	localparam logic [ADDR_W-1:0] RAM_PRE_P = 16'h4008;
	localparam logic [ADDR_W-1:0] RAM_PRE_O = 16'h3FFF;

endpackage

// File: source/ce_gen.sv
// clock enable generator

module ce_gen
	import zx_tape_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu_o,
	output logic ce_slow_o
);

	// free running divider
	logic [CE_DIV_W-1:0] div_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt   <= '0;
			ce_cpu_o  <= 1'b0;
			ce_slow_o <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			// cpu enable, low four bits at zero
			// one pulse per 16 clocks
			ce_cpu_o <= (div_cnt[3:0] == 4'd0);
			// whole counter at zero, every 32 clocks
			ce_slow_o <= (div_cnt == '0);
		end
	end

endmodule

// File: source/tape_buffer.sv
// tape image buffer

module tape_buffer
	import zx_tape_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,
	// download stream
	input  logic               dl_valid_i,
	output logic               dl_ready_o,
	input  logic [TAPE_AW-1:0] dl_addr_i,
	input  logic [BYTE_W-1:0]  dl_data_i,
	input  logic               dl_type_i,
	// loader side
	input  logic               busy_i,
	input  logic [TAPE_AW-1:0] rd_addr_i,
	output logic [BYTE_W-1:0]  rd_data_o,
	output logic [TAPE_AW-1:0] size_o,
	output logic               type_o
);

	logic [BYTE_W-1:0] tape_mem [0:2**TAPE_AW-1];
	logic dl_accept;

	// no downloads while the copier reads the buffer
	assign dl_ready_o = ~busy_i;
	assign dl_accept = dl_valid_i & dl_ready_o;

	// ========================================
	// storage
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (dl_accept) begin
			tape_mem[dl_addr_i] <= dl_data_i;
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge clk_sys) begin
		rd_data_o <= tape_mem[rd_addr_i];
	end

	// size tracks the highest byte so far
	// type 1 is .p, 0 is .o
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			size_o <= '0;
			type_o <= 1'b0;
		end else if (dl_accept) begin
			size_o <= dl_addr_i + 1'b1;
			type_o <= dl_type_i;
		end
	end

endmodule

// File: source/load_trap.sv
// load routine trap

module load_trap
	import zx_tape_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic [ADDR_W-1:0] cpu_addr_i,
	input  logic              cpu_m1_n_i,
	input  logic              zx81_i,
	input  logic              tape_present_i,
	output logic              loading_o,
	output logic              load_start_o
);

	logic              m1_n_q;
	logic              fetch_start;
	logic              trap_hit;
	logic              win_exit;
	logic [ADDR_W-1:0] trap_addr;
	logic [ADDR_W-1:0] win_end;

	// ========================================
	// model select
	// ========================================

	assign trap_addr = zx81_i ? TRAP_ZX81 : TRAP_ZX80;
	assign win_end   = zx81_i ? WIN_END_ZX81 : WIN_END_ZX80;

	// opcode fetch begins on falling m1
	assign fetch_start = m1_n_q & ~cpu_m1_n_i;

	// entry into the load routine with a tape present
	// a running load is not restarted
	assign trap_hit = fetch_start & (cpu_addr_i == trap_addr)
		& tape_present_i & ~loading_o;

	// fetch anywhere outside the routine
	assign win_exit = fetch_start
		& ((cpu_addr_i < trap_addr) | (cpu_addr_i >= win_end));

	// ========================================
	// loading state
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_n_q       <= 1'b1;
			loading_o    <= 1'b0;
			load_start_o <= 1'b0;
		end else begin
			m1_n_q <= cpu_m1_n_i;
			// start pulse lines up with the rise of loading
			load_start_o <= trap_hit;
			if (trap_hit) begin
				loading_o <= 1'b1;
			end else if (win_exit) begin
				loading_o <= 1'b0;
			end
		end
	end

endmodule

// File: source/patch_rom.sv
// patch routine rom

module patch_rom
	import zx_tape_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              zx81_i,
	input  logic [ADDR_W-1:0] cpu_addr_i,
	input  logic              loading_i,
	input  logic              load_start_i,
	input  logic              tape_end_i,
	output logic              patch_sel_o,
	output logic [BYTE_W-1:0] patch_data_o
);

	// only byte 1 and byte 5 ever change
	logic [BYTE_W-1:0] loop_op;
	logic [BYTE_W-1:0] jmp_lo;
	logic [ADDR_W-1:0] trap_addr;
	logic [ADDR_W-1:0] offset;

	assign trap_addr = zx81_i ? TRAP_ZX81 : TRAP_ZX80;

	// ========================================
	// writable bytes
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loop_op <= PATCH_IMAGE[1];
			jmp_lo  <= PATCH_IMAGE[5];
		end else if (load_start_i) begin
			// loop until the copier runs dry
			loop_op <= OP_NOP;
			jmp_lo  <= zx81_i ? JMP_LO_ZX81 : JMP_LO_ZX80;
		end else if (tape_end_i) begin
			// carry set, jr nc falls through
			loop_op <= OP_SCF;
		end
	end

	// ========================================
	// read-out
	// ========================================

	// below the trap the difference wraps high,
	// so one compare covers both bounds
	assign offset = cpu_addr_i - trap_addr;
	assign patch_sel_o = loading_i & (offset < ADDR_W'(PATCH_LEN));

	always_comb begin
		patch_data_o = '0;
		if (patch_sel_o) begin
			for (int i = 0; i < PATCH_LEN; i++) begin
				if (offset == ADDR_W'(i)) begin
					patch_data_o = PATCH_IMAGE[i];
				end
			end
			if (offset == ADDR_W'(1)) begin
				patch_data_o = loop_op;
			end
			if (offset == ADDR_W'(5)) begin
				patch_data_o = jmp_lo;
			end
		end
	end

endmodule

// File: source/tape_copier.sv
// tape to ram copier

module tape_copier
	import zx_tape_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               ce_cpu_i,
	input  logic               loading_i,
	input  logic               load_start_i,
	input  logic               tape_type_i,
	input  logic [TAPE_AW-1:0] tape_size_i,
	output logic [TAPE_AW-1:0] rd_addr_o,
	input  logic [BYTE_W-1:0]  rd_data_i,
	output logic               ram_we_o,
	output logic [ADDR_W-1:0]  ram_addr_o,
	output logic [BYTE_W-1:0]  ram_data_o,
	output logic               tape_end_o
);

	logic [TAPE_AW-1:0] buf_ptr;
	logic [ADDR_W-1:0]  ram_ptr;
	logic [BYTE_W-1:0]  data_q;
	logic               step_q;
	logic               wr_q;
	logic               bytes_left;

	assign bytes_left = (buf_ptr < tape_size_i);
	// buffer data for buf_ptr shows up one cycle later
	assign rd_addr_o = buf_ptr;

	// ========================================
	// pointers
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			buf_ptr    <= '0;
			ram_ptr    <= '0;
			step_q     <= 1'b0;
			tape_end_o <= 1'b0;
		end else begin
			step_q     <= 1'b0;
			tape_end_o <= 1'b0;
			if (load_start_i) begin
				buf_ptr <= '0;
				ram_ptr <= tape_type_i ? RAM_PRE_P : RAM_PRE_O;
			end else if (ce_cpu_i && loading_i) begin
				if (bytes_left) begin
					// read of the old pointer is in flight now
					buf_ptr <= buf_ptr + 1'b1;
					ram_ptr <= ram_ptr + 1'b1;
					step_q  <= 1'b1;
				end else begin
					// nothing left, the patch may exit its loop
					tape_end_o <= 1'b1;
				end
			end
		end
	end

	// ========================================
	// write stage
	// ========================================

	// byte latched the cycle after the step,
	// written the cycle after that
	always_ff @(posedge clk_sys) begin
		if (step_q) begin
			data_q <= rd_data_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_q <= 1'b0;
		end else begin
			wr_q <= step_q & loading_i;
		end
	end

	// a load cut short drops its last pending write
	assign ram_we_o   = wr_q & loading_i;
	assign ram_addr_o = ram_ptr;
	assign ram_data_o = data_q;

endmodule

// File: source/ear_input.sv
// ear input conditioning

module ear_input (
	input  logic clk_sys,
	input  logic reset,
	input  logic ear_i,
	input  logic ce_slow_i,
	input  logic loading_i,
	output logic tape_in_o,
	output logic tape_led_o
);

	// two past samples, the live input is the third
	logic ear_z1;
	logic ear_z2;
	logic tape_bit;
	logic glitch;

	// middle sample differs from both neighbours
	assign glitch = (ear_z1 != ear_z2) & (ear_z1 != ear_i);

	// ========================================
	// sampler and pulse filter
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear_z1   <= 1'b0;
			ear_z2   <= 1'b0;
			tape_bit <= 1'b0;
		end else begin
			ear_z1 <= ear_i;
			ear_z2 <= ear_z1;
			// isolated middle sample is dropped
			tape_bit <= glitch ? ear_i : ear_z1;
		end
	end

	// led follows a stable high level, slow rate
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tape_led_o <= 1'b0;
		end else if (ce_slow_i) begin
			tape_led_o <= tape_bit & ear_z1 & ear_z2;
		end
	end

	// cpu reads inverted level, held low during fast load
	assign tape_in_o = loading_i ? 1'b0 : ~tape_bit;

endmodule

// File: source/zx_tape_top.sv
// fast tape loader core

module zx_tape_top
	import zx_tape_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               zx81_i,
	// download stream
	input  logic               dl_valid_i,
	output logic               dl_ready_o,
	input  logic [TAPE_AW-1:0] dl_addr_i,
	input  logic [BYTE_W-1:0]  dl_data_i,
	input  logic               dl_type_i,
	// cpu bus and ear
	input  logic [ADDR_W-1:0]  cpu_addr_i,
	input  logic               cpu_m1_n_i,
	input  logic               ear_i,
	// rom side
	output logic               loading_o,
	output logic               patch_sel_o,
	output logic [BYTE_W-1:0]  patch_data_o,
	// ram write port
	output logic               ram_we_o,
	output logic [ADDR_W-1:0]  ram_addr_o,
	output logic [BYTE_W-1:0]  ram_data_o,
	// tape bit and led
	output logic               tape_in_o,
	output logic               tape_led_o
);

	logic               ce_cpu;
	logic               ce_slow;
	logic               load_start;
	logic               tape_end;
	logic               tape_type;
	logic               tape_present;
	logic [TAPE_AW-1:0] tape_size;
	logic [TAPE_AW-1:0] rd_addr;
	logic [BYTE_W-1:0]  rd_data;

	assign tape_present = (tape_size != '0);

	ce_gen i_ce_gen (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ce_cpu_o  (ce_cpu),
		.ce_slow_o (ce_slow)
	);

	// ========================================
	// tape storage and copy
	// ========================================

	tape_buffer i_tape_buffer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_valid_i (dl_valid_i),
		.dl_ready_o (dl_ready_o),
		.dl_addr_i  (dl_addr_i),
		.dl_data_i  (dl_data_i),
		.dl_type_i  (dl_type_i),
		.busy_i     (loading_o),
		.rd_addr_i  (rd_addr),
		.rd_data_o  (rd_data),
		.size_o     (tape_size),
		.type_o     (tape_type)
	);

	tape_copier i_tape_copier (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ce_cpu_i     (ce_cpu),
		.loading_i    (loading_o),
		.load_start_i (load_start),
		.tape_type_i  (tape_type),
		.tape_size_i  (tape_size),
		.rd_addr_o    (rd_addr),
		.rd_data_i    (rd_data),
		.ram_we_o     (ram_we_o),
		.ram_addr_o   (ram_addr_o),
		.ram_data_o   (ram_data_o),
		.tape_end_o   (tape_end)
	);

	// ========================================
	// cpu side
	// ========================================

	load_trap i_load_trap (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_m1_n_i     (cpu_m1_n_i),
		.zx81_i         (zx81_i),
		.tape_present_i (tape_present),
		.loading_o      (loading_o),
		.load_start_o   (load_start)
	);

	patch_rom i_patch_rom (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.zx81_i       (zx81_i),
		.cpu_addr_i   (cpu_addr_i),
		.loading_i    (loading_o),
		.load_start_i (load_start),
		.tape_end_i   (tape_end),
		.patch_sel_o  (patch_sel_o),
		.patch_data_o (patch_data_o)
	);

	ear_input i_ear_input (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ear_i      (ear_i),
		.ce_slow_i  (ce_slow),
		.loading_i  (loading_o),
		.tape_in_o  (tape_in_o),
		.tape_led_o (tape_led_o)
	);

endmodule

// File: bench/zx_tape_chk.sv
// loader protocol assertions

module zx_tape_chk (
	input logic        clk_sys,
	input logic        reset,
	input logic        loading_i,
	input logic        dl_ready_i,
	input logic        ram_we_i,
	input logic [15:0] ram_addr_i
);

	timeunit 1ns;
	timeprecision 1ps;

	logic        have_prev;
	logic [15:0] prev_addr;
	// sticky failure flags, read by the testbench at the end
	logic        we_fail = 1'b0;
	logic        ready_fail = 1'b0;
	logic        seq_fail = 1'b0;
	logic        any_fail;

	assign any_fail = we_fail | ready_fail | seq_fail;

	// last write address of the running load
	always_ff @(posedge clk_sys) begin
		if (reset || !loading_i) begin
			have_prev <= 1'b0;
			prev_addr <= '0;
		end else if (ram_we_i) begin
			have_prev <= 1'b1;
			prev_addr <= ram_addr_i;
		end
	end

	// ========================================
	// rules
	// ========================================

	we_in_load: assert property (@(posedge clk_sys) disable iff (reset)
		ram_we_i |-> loading_i)
		else begin
			$error("RAM write outside a load");
			we_fail = 1'b1;
		end

	// buffer is being read, downloads blocked
	ready_in_load: assert property (@(posedge clk_sys) disable iff (reset)
		loading_i |-> !dl_ready_i)
		else begin
			$error("download ready during a load");
			ready_fail = 1'b1;
		end

	addr_in_seq: assert property (@(posedge clk_sys) disable iff (reset)
		(ram_we_i && have_prev) |-> (ram_addr_i == prev_addr + 16'd1))
		else begin
			$error("RAM write address not consecutive");
			seq_fail = 1'b1;
		end

endmodule

// File: bench/tb_zx_tape.sv
// fast tape loader testbench

module tb_zx_tape;

	timeunit 1ns;
	timeprecision 1ps;

	// ========================================
	// run constants
	// ========================================

	localparam int CLK_PERIOD = 100;
	localparam int DRV_DLY = 10;
	// combinational settle after an address change
	localparam int SETTLE = 5;
	localparam int NUM_TESTS = 8;
	// 64 byte tape at one byte per 16 clocks, plus download, ear and led
	localparam int TEST_CYCLES = 2000;
	localparam int MARGIN = 2;
	// steady ear level across one slow enable period and the sampler
	localparam int LED_WAIT = 40;

	logic        clk_sys;
	logic        reset;
	logic        zx81;
	logic        dl_valid;
	logic        dl_ready;
	logic [13:0] dl_addr;
	logic [7:0]  dl_data;
	logic        dl_type;
	logic [15:0] cpu_addr;
	logic        cpu_m1_n;
	logic        ear;
	logic        loading;
	logic        patch_sel;
	logic [7:0]  patch_data;
	logic        ram_we;
	logic [15:0] ram_addr;
	logic [7:0]  ram_data;
	logic        tape_in;
	logic        tape_led;

	// reference model state
	integer      seed;
	logic [7:0]  tape_ref [$];
	logic [7:0]  patch_ref [0:6];
	int          tape_len;
	logic [15:0] ram_first;
	int          wr_base;
	int          wr_seen = 0;
	logic        ear_level;

	zx_tape_top i_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.zx81_i       (zx81),
		.dl_valid_i   (dl_valid),
		.dl_ready_o   (dl_ready),
		.dl_addr_i    (dl_addr),
		.dl_data_i    (dl_data),
		.dl_type_i    (dl_type),
		.cpu_addr_i   (cpu_addr),
		.cpu_m1_n_i   (cpu_m1_n),
		.ear_i        (ear),
		.loading_o    (loading),
		.patch_sel_o  (patch_sel),
		.patch_data_o (patch_data),
		.ram_we_o     (ram_we),
		.ram_addr_o   (ram_addr),
		.ram_data_o   (ram_data),
		.tape_in_o    (tape_in),
		.tape_led_o   (tape_led)
	);

	bind zx_tape_top zx_tape_chk i_chk (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.loading_i  (loading_o),
		.dl_ready_i (dl_ready_o),
		.ram_we_i   (ram_we_o),
		.ram_addr_i (ram_addr_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// watchdog, sized from the worst case test length
	initial begin
		#(NUM_TESTS * TEST_CYCLES * MARGIN * CLK_PERIOD);
		abort_run("timeout, the run did not finish in time");
	end

	// ========================================
	// helpers
	// ========================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (act_val !== exp_val) begin
			$display("ERR %s expected %h actual %h", name, exp_val, act_val);
			abort_run("value mismatch");
		end
	endtask

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	// drive point, just after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#DRV_DLY;
	endtask

	function automatic logic [15:0] trap_of(input logic model81);
		return model81 ? 16'h0347 : 16'h0207;
	endfunction

	function automatic logic [15:0] win_end_of(input logic model81);
		return model81 ? 16'h03C3 : 16'h024D;
	endfunction

	// one m1 low cycle, then back high
	task automatic cpu_fetch(input logic [15:0] addr);
		cpu_addr = addr;
		cpu_m1_n = 1'b0;
		step();
		cpu_m1_n = 1'b1;
		step();
	endtask

	// hold the offered byte until an edge sees ready
	task automatic wait_accept();
		int   waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		while (!taken) begin
			taken = dl_ready;
			step();
			waited++;
			if (waited > TEST_CYCLES) begin
				abort_run("a download byte was never accepted");
			end
		end
	endtask

	task automatic download_tape();
		logic [31:0] rnd;
		int          gap;
		for (int i = 0; i < tape_len; i++) begin
			rnd = next_rand();
			gap = int'(rnd[1:0]);
			// random idle cycles between bytes
			dl_valid = 1'b0;
			repeat (gap) step();
			dl_valid = 1'b1;
			dl_addr = 14'(i);
			dl_data = tape_ref[i];
			wait_accept();
		end
		dl_valid = 1'b0;
	endtask

	// xor a / loop byte / jr nc / jp, low byte by model
	task automatic build_patch_ref(input logic [7:0] loop_byte);
		patch_ref[0] = 8'hAF;
		patch_ref[1] = loop_byte;
		patch_ref[2] = 8'h30;
		patch_ref[3] = 8'hFD;
		patch_ref[4] = 8'hC3;
		patch_ref[5] = zx81 ? 8'h07 : 8'h03;
		patch_ref[6] = 8'h02;
	endtask

	// window read-out, m1 stays high
	task automatic check_patch(input logic [7:0] loop_byte);
		logic [15:0] trap;
		logic [15:0] offs;
		logic [31:0] rnd;
		logic        sel_exp;
		logic [15:0] probe [$];
		trap = trap_of(zx81);
		build_patch_ref(loop_byte);
		for (int k = 0; k < 7; k++) begin
			probe.push_back(trap + 16'(k));
		end
		// both edges of the window, then anywhere
		probe.push_back(trap - 16'd1);
		probe.push_back(trap + 16'd7);
		for (int k = 0; k < 3; k++) begin
			rnd = next_rand();
			probe.push_back(rnd[15:0]);
		end
		for (int k = 0; k < probe.size(); k++) begin
			step();
			cpu_addr = probe[k];
			#SETTLE;
			sel_exp = (probe[k] >= trap) && (probe[k] < trap + 16'd7);
			compare_value("patch_sel_o", 32'(sel_exp), 32'(patch_sel));
			if (sel_exp) begin
				offs = probe[k] - trap;
				compare_value("patch_data_o", 32'(patch_ref[offs[2:0]]), 32'(patch_data));
			end
		end
	endtask

	// loop byte turns to scf once the copier runs dry
	task automatic wait_tape_end();
		logic [31:0] rnd;
		int          waited;
		cpu_addr = trap_of(zx81) + 16'd1;
		#SETTLE;
		waited = 0;
		while (patch_data !== 8'h37) begin
			// ear noise, must not reach the cpu while loading
			rnd = next_rand();
			ear = rnd[0];
			step();
			waited++;
			if (waited > TEST_CYCLES) begin
				abort_run("patch loop byte never changed to SCF");
			end
		end
	endtask

	task automatic ear_hold(input logic level);
		int waited;
		ear = level;
		ear_level = level;
		waited = 0;
		step();
		while (tape_in !== ~level) begin
			waited++;
			if (waited >= 3) begin
				abort_run("tape_in_o did not follow a held EAR level");
			end
			step();
		end
		repeat (2) begin
			step();
			compare_value("tape_in_o", {31'd0, ~level}, 32'(tape_in));
		end
	endtask

	// single cycle spike, filtered out
	task automatic ear_pulse();
		ear = ~ear_level;
		step();
		compare_value("tape_in_o", {31'd0, ~ear_level}, 32'(tape_in));
		ear = ear_level;
		repeat (3) begin
			step();
			compare_value("tape_in_o", {31'd0, ~ear_level}, 32'(tape_in));
		end
	endtask

	// led lights only on a steady high level
	task automatic check_led(input logic level);
		ear = level;
		ear_level = level;
		repeat (LED_WAIT) step();
		compare_value("tape_led_o", {31'd0, level}, 32'(tape_led));
	endtask

	// ========================================
	// ram write and tape bit monitor
	// ========================================

	always @(negedge clk_sys) begin : ram_monitor
		int idx;
		if (!reset) begin
			if (loading) begin
				compare_value("tape_in_o", 32'd0, 32'(tape_in));
			end
			if (ram_we) begin
				idx = wr_seen - wr_base;
				if (idx >= tape_len) begin
					abort_run("more RAM writes than tape bytes");
				end
				compare_value("ram_addr_o", 32'(ram_first + 16'(idx)), 32'(ram_addr));
				compare_value("ram_data_o", 32'(tape_ref[idx]), 32'(ram_data));
				wr_seen = wr_seen + 1;
			end
		end
	end

	// ========================================
	// main sequence
	// ========================================

	initial begin
		logic [31:0] rnd;
		logic [15:0] trap;
		logic [15:0] span;
		logic [15:0] exit_addr;
		seed = 72;
		reset = 1'b1;
		zx81 = 1'b1;
		dl_valid = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		dl_type = 1'b0;
		cpu_addr = '0;
		cpu_m1_n = 1'b1;
		ear = 1'b0;
		ear_level = 1'b0;
		tape_len = 0;
		wr_base = 0;
		ram_first = '0;
		repeat (2) step();
		reset = 1'b0;

		compare_value("loading_o", 32'd0, 32'(loading));
		compare_value("ram_we_o", 32'd0, 32'(ram_we));
		compare_value("patch_sel_o", 32'd0, 32'(patch_sel));
		compare_value("dl_ready_o", 32'd1, 32'(dl_ready));

		// trap with an empty buffer
		rnd = next_rand();
		zx81 = rnd[0];
		cpu_fetch(trap_of(zx81));
		step();
		compare_value("loading_o", 32'd0, 32'(loading));

		for (int t = 0; t < NUM_TESTS; t++) begin
			rnd = next_rand();
			zx81 = rnd[0];
			dl_type = rnd[1];
			tape_len = 1 + int'(rnd[7:2]);
			// .p skips the system variables
			ram_first = dl_type ? 16'h4009 : 16'h4000;
			tape_ref.delete();
			for (int i = 0; i < tape_len; i++) begin
				rnd = next_rand();
				tape_ref.push_back(rnd[7:0]);
			end
			wr_base = wr_seen;
			download_tape();
			step();

			trap = trap_of(zx81);
			cpu_fetch(trap);
			compare_value("loading_o", 32'd1, 32'(loading));
			compare_value("dl_ready_o", 32'd0, 32'(dl_ready));
			check_patch(8'h00);

			wait_tape_end();
			compare_value("write count", 32'(tape_len), 32'(wr_seen - wr_base));
			check_patch(8'h37);

			// fetch inside the routine keeps the load running
			rnd = next_rand();
			span = win_end_of(zx81) - trap;
			cpu_fetch(trap + (rnd[15:0] % span));
			compare_value("loading_o", 32'd1, 32'(loading));

			// download offered while loading waits
			rnd = next_rand();
			dl_valid = 1'b1;
			dl_addr = '0;
			dl_data = rnd[7:0];
			dl_type = rnd[8];
			step();
			compare_value("dl_ready_o", 32'd0, 32'(dl_ready));
			if (rnd[9]) begin
				exit_addr = win_end_of(zx81) + 16'(rnd[19:10]);
			end else begin
				// below 0200h, under both traps
				exit_addr = 16'(rnd[18:10]);
			end
			cpu_fetch(exit_addr);
			compare_value("loading_o", 32'd0, 32'(loading));
			wait_accept();
			dl_valid = 1'b0;

			// ear path, idle
			rnd = next_rand();
			ear_hold(rnd[0]);
			repeat (6) begin
				rnd = next_rand();
				if (rnd[0]) begin
					ear_pulse();
				end else begin
					ear_hold(rnd[1]);
				end
			end

			// tape led, on then off
			check_led(1'b1);
			check_led(1'b0);
		end

		step();
		if (i_dut.i_chk.any_fail == 1'b0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("ERRORS FOUND");
			$fatal(1, "assertion failures in the checker");
		end
	end

endmodule

// File: zx_tape.f
source/zx_tape_pkg.sv
source/ce_gen.sv
source/tape_buffer.sv
source/load_trap.sv
source/patch_rom.sv
source/tape_copier.sv
source/ear_input.sv
source/zx_tape_top.sv
bench/zx_tape_chk.sv
bench/tb_zx_tape.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_zx_tape
FILELIST  := zx_tape.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
